//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = rvCoreTb
FILELIST  = rvCore.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir

//--- hdl/alu.sv
`timescale 1ns/1ps

module alu import rvPkg::*; (
    input  logic [xlen-1:0] a,
    input  logic [xlen-1:0] b,
    input  aluOp            aluSel,
    input  branchCond       brCond,
    output logic [xlen-1:0] result,
    output logic            brTaken
);
    logic [4:0] shamt;
    logic       ltSigned;
    logic       ltUnsigned;

    assign shamt      = b[4:0];
    assign ltSigned   = $signed(a) < $signed(b);
    assign ltUnsigned = a < b;

    always_comb begin
        case (aluSel)
            aluAdd:   result = a + b;
            aluSub:   result = a - b;
            aluSll:   result = a << shamt;
            aluSlt:   result = {{(xlen-1){1'b0}}, ltSigned};
            aluSltu:  result = {{(xlen-1){1'b0}}, ltUnsigned};
            aluXor:   result = a ^ b;
            aluSrl:   result = a >> shamt;
            aluSra:   result = $unsigned($signed(a) >>> shamt);  // sign fill
            aluOr:    result = a | b;
            aluAnd:   result = a & b;
            aluPassB: result = b;
            default:  result = '0;
        endcase
    end

    // same operands as the register-register path
    always_comb begin
        case (brCond)
            brEq:    brTaken = (a == b);
            brNe:    brTaken = (a != b);
            brLt:    brTaken = ltSigned;
            brGe:    brTaken = !ltSigned;
            brLtu:   brTaken = ltUnsigned;
            brGeu:   brTaken = !ltUnsigned;
            default: brTaken = 1'b0;
        endcase
    end

endmodule

//--- hdl/coreControl.sv
`timescale 1ns/1ps

module coreControl import rvPkg::*; #(
    parameter logic [xlen-1:0] resetPc = '0
) (
    input  logic            clk,
    input  logic            arstN,
    input  opCode           op,
    input  logic            isLegal,
    input  logic [xlen-1:0] imm,
    input  logic [xlen-1:0] result,
    input  logic            brTaken,
    input  logic            memAck,
    input  logic [xlen-1:0] memRdata,
    input  logic [xlen-1:0] rs2Data,
    output logic [xlen-1:0] instr,
    output logic [xlen-1:0] pcOut,
    output logic            aluASel,
    output logic            aluBSel,
    output logic            wrEn,
    output logic [xlen-1:0] wrData,
    output logic            memReq,
    output logic            memWe,
    output logic [xlen-1:0] memAddr,
    output logic [xlen-1:0] memWdata,
    output logic            halted
);
    ctrlState        state;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] pcPlus4;
    logic [xlen-1:0] pcTarget;
    logic [xlen-1:0] nextPc;
    logic [xlen-1:0] aluRes;
    logic [xlen-1:0] loadData;
    logic            taken;
    logic            ackSeen;
    logic            busState;
    logic            writesRd;

    assign pcPlus4  = pc + 32'd4;
    assign pcTarget = pc + imm;
    assign busState = (state == stFetch) || (state == stMemory);

    assign writesRd = (op == opOp) || (op == opOpImm) || (op == opLui) ||
                      (op == opAuipc) || (op == opLoad) || (op == opJal) || (op == opJalr);

    always_comb begin
        if (op == opJal || (op == opBranch && taken)) begin
            nextPc = pcTarget;
        end else if (op == opJalr) begin
            nextPc = {aluRes[xlen-1:1], 1'b0};  // JALR clears bit zero
        end else begin
            nextPc = pcPlus4;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state   <= stFetch;
            pc      <= resetPc;
            instr   <= '0;
            memReq  <= 1'b0;
            ackSeen <= 1'b0;
            taken   <= 1'b0;
        end else begin
            if (busState) begin
                if (!memReq && !ackSeen && !memAck) begin
                    memReq <= 1'b1;
                end else if (memReq && memAck) begin
                    memReq  <= 1'b0;
                    ackSeen <= 1'b1;
                    if (state == stFetch) begin
                        instr <= memRdata;
                    end
                end else if (ackSeen && !memAck) begin  // four phases complete
                    ackSeen <= 1'b0;
                    state   <= (state == stFetch) ? stExecute : stWriteback;
                end
            end
            case (state)
                stExecute: begin
                    taken <= brTaken;
                    if (!isLegal || op == opSystem) begin
                        state <= stHalt;
                    end else if (op == opLoad || op == opStore) begin
                        state <= stMemory;
                    end else begin
                        state <= stWriteback;
                    end
                end
                stWriteback: begin
                    pc    <= nextPc;
                    state <= stFetch;
                end
                default: ;
            endcase
        end
    end

    // operand and load capture
    always_ff @(posedge clk) begin
        if (state == stExecute) begin
            aluRes <= result;
        end
        if (state == stMemory && memReq && memAck) begin
            loadData <= memRdata;
        end
    end

    always_comb begin
        case (op)
            opLoad:        wrData = loadData;
            opJal, opJalr: wrData = pcPlus4;  // link address
            default:       wrData = aluRes;
        endcase
    end

    assign pcOut    = pc;
    assign aluASel  = (op == opAuipc);
    assign aluBSel  = !((op == opOp) || (op == opBranch));
    assign wrEn     = (state == stWriteback) && writesRd;
    assign memWe    = (state == stMemory) && (op == opStore);
    assign memAddr  = (state == stMemory) ? aluRes : pc;
    assign memWdata = rs2Data;
    assign halted   = (state == stHalt);

endmodule

//--- hdl/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder import rvPkg::*; (
    input  logic [xlen-1:0]         instr,
    output opCode                   op,
    output logic [regAddrWidth-1:0] rs1Addr,
    output logic [regAddrWidth-1:0] rs2Addr,
    output logic [regAddrWidth-1:0] rdAddr,
    output logic [xlen-1:0]         imm,
    output aluOp                    aluSel,
    output branchCond               brCond,
    output logic                    isLegal
);
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [xlen-1:0] immI;
    logic [xlen-1:0] immS;
    logic [xlen-1:0] immB;
    logic [xlen-1:0] immU;
    logic [xlen-1:0] immJ;
    aluOp            baseOp;

    assign funct3  = instr[14:12];
    assign funct7  = instr[31:25];
    assign rs1Addr = instr[19:15];
    assign rs2Addr = instr[24:20];
    assign rdAddr  = instr[11:7];

    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign immU = {instr[31:12], 12'b0};
    assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // funct3 mapping shared by OP and OP_IMM
    always_comb begin
        case (funct3)
            3'b000:  baseOp = aluAdd;
            3'b001:  baseOp = aluSll;
            3'b010:  baseOp = aluSlt;
            3'b011:  baseOp = aluSltu;
            3'b100:  baseOp = aluXor;
            3'b101:  baseOp = funct7[5] ? aluSra : aluSrl;
            3'b110:  baseOp = aluOr;
            default: baseOp = aluAnd;
        endcase
    end

    always_comb begin
        op      = opIllegal;
        imm     = immI;
        aluSel  = aluAdd;   // address and link arithmetic
        isLegal = 1'b0;
        case (instr[6:0])
            opLoad: begin
                op      = opLoad;
                isLegal = (funct3 == 3'b010);  // word only
            end
            opStore: begin
                op      = opStore;
                imm     = immS;
                isLegal = (funct3 == 3'b010);
            end
            opOpImm: begin
                op      = opOpImm;
                aluSel  = baseOp;
                isLegal = (funct3 == 3'b001) ? (funct7 == 7'b0) :
                          (funct3 == 3'b101) ? (funct7 == 7'b0 || funct7 == 7'b0100000) :
                          1'b1;
            end
            opOp: begin
                op      = opOp;
                aluSel  = (funct3 == 3'b000 && funct7[5]) ? aluSub : baseOp;
                isLegal = (funct7 == 7'b0) ||
                          (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
            end
            opLui: begin
                op      = opLui;
                imm     = immU;
                aluSel  = aluPassB;
                isLegal = 1'b1;
            end
            opAuipc: begin
                op      = opAuipc;
                imm     = immU;
                isLegal = 1'b1;
            end
            opBranch: begin
                op      = opBranch;
                imm     = immB;
                isLegal = (funct3[2:1] != 2'b01);  // 010 and 011 unused
            end
            opJal: begin
                op      = opJal;
                imm     = immJ;
                isLegal = 1'b1;
            end
            opJalr: begin
                op      = opJalr;
                isLegal = (funct3 == 3'b000);
            end
            opSystem: begin
                op      = opSystem;
                isLegal = 1'b1;  // legal but halts
            end
            default: ;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b001:  brCond = brNe;
            3'b100:  brCond = brLt;
            3'b101:  brCond = brGe;
            3'b110:  brCond = brLtu;
            3'b111:  brCond = brGeu;
            default: brCond = brEq;
        endcase
    end

endmodule

//--- hdl/regFile.sv
`timescale 1ns/1ps

module regFile import rvPkg::*; (
    input  logic                    clk,
    input  logic                    arstN,
    input  logic [regAddrWidth-1:0] rs1Addr,
    input  logic [regAddrWidth-1:0] rs2Addr,
    input  logic [regAddrWidth-1:0] rdAddr,
    input  logic                    wrEn,
    input  logic [xlen-1:0]         wrData,
    output logic [xlen-1:0]         rs1Data,
    output logic [xlen-1:0]         rs2Data
);
    localparam int depth = 2 ** regAddrWidth;

    logic [xlen-1:0] regs [depth];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < depth; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && rdAddr != '0) begin  // x0 never written
            regs[rdAddr] <= wrData;
        end
    end

    assign rs1Data = regs[rs1Addr];
    assign rs2Data = regs[rs2Addr];

endmodule

//--- hdl/rvCore.sv
`timescale 1ns/1ps

module rvCore import rvPkg::*; #(
    parameter logic [xlen-1:0] resetPc = '0
) (
    input  logic            clk,
    input  logic            arstN,
    output logic            memReq,
    input  logic            memAck,
    output logic            memWe,
    output logic [xlen-1:0] memAddr,
    output logic [xlen-1:0] memWdata,
    input  logic [xlen-1:0] memRdata,
    output logic            halted
);
    logic [xlen-1:0]         instr;
    opCode                   op;
    logic [regAddrWidth-1:0] rs1Addr;
    logic [regAddrWidth-1:0] rs2Addr;
    logic [regAddrWidth-1:0] rdAddr;
    logic [xlen-1:0]         imm;
    aluOp                    aluSel;
    branchCond               brCond;
    logic                    isLegal;
    logic [xlen-1:0]         rs1Data;
    logic [xlen-1:0]         rs2Data;
    logic [xlen-1:0]         aluA;
    logic [xlen-1:0]         aluB;
    logic [xlen-1:0]         result;
    logic                    brTaken;
    logic [xlen-1:0]         pcOut;
    logic                    aluASel;
    logic                    aluBSel;
    logic                    wrEn;
    logic [xlen-1:0]         wrData;

    assign aluA = aluASel ? pcOut : rs1Data;  // PC for AUIPC
    assign aluB = aluBSel ? imm : rs2Data;

    instrDecoder uDecoder (
        .instr(instr), .op(op), .rs1Addr(rs1Addr), .rs2Addr(rs2Addr), .rdAddr(rdAddr),
        .imm(imm), .aluSel(aluSel), .brCond(brCond), .isLegal(isLegal)
    );

    alu uAlu (
        .a(aluA), .b(aluB), .aluSel(aluSel), .brCond(brCond),
        .result(result), .brTaken(brTaken)
    );

    regFile uRegFile (
        .clk(clk), .arstN(arstN), .rs1Addr(rs1Addr), .rs2Addr(rs2Addr), .rdAddr(rdAddr),
        .wrEn(wrEn), .wrData(wrData), .rs1Data(rs1Data), .rs2Data(rs2Data)
    );

    coreControl #(.resetPc(resetPc)) uControl (
        .clk(clk), .arstN(arstN), .op(op), .isLegal(isLegal), .imm(imm),
        .result(result), .brTaken(brTaken), .memAck(memAck), .memRdata(memRdata),
        .rs2Data(rs2Data), .instr(instr), .pcOut(pcOut), .aluASel(aluASel),
        .aluBSel(aluBSel), .wrEn(wrEn), .wrData(wrData), .memReq(memReq),
        .memWe(memWe), .memAddr(memAddr), .memWdata(memWdata), .halted(halted)
    );

endmodule

//--- hdl/rvPkg.sv
package rvPkg;

    localparam int xlen         = 32;
    localparam int regAddrWidth = 5;

    // major opcodes, full seven bits with the low 2'b11 included
    typedef enum logic [6:0] {
        opLoad    = 7'b0000011,
        opStore   = 7'b0100011,
        opOpImm   = 7'b0010011,
        opOp      = 7'b0110011,
        opLui     = 7'b0110111,
        opAuipc   = 7'b0010111,
        opBranch  = 7'b1100011,
        opJal     = 7'b1101111,
        opJalr    = 7'b1100111,
        opSystem  = 7'b1110011,
        opIllegal = 7'b0000000  // anything not listed above
    } opCode;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluSll,
        aluSlt,
        aluSltu,
        aluXor,
        aluSrl,
        aluSra,
        aluOr,
        aluAnd,
        aluPassB  // LUI
    } aluOp;

    // encoded as the BRANCH funct3 field
    typedef enum logic [2:0] {
        brEq  = 3'b000,
        brNe  = 3'b001,
        brLt  = 3'b100,
        brGe  = 3'b101,
        brLtu = 3'b110,
        brGeu = 3'b111
    } branchCond;

    typedef enum logic [2:0] {
        stFetch,
        stExecute,
        stMemory,   // LOAD and STORE only
        stWriteback,
        stHalt
    } ctrlState;

endpackage

//--- rvCore.f
hdl/rvPkg.sv
hdl/instrDecoder.sv
hdl/alu.sv
hdl/regFile.sv
hdl/coreControl.sv
hdl/rvCore.sv
sim/busProtocol_chk.sv
sim/rvCoreTb.sv

//--- sim/busProtocol_chk.sv
`timescale 1ns/1ps

module busProtocolChk import rvPkg::*; (
    input logic            clk,
    input logic            arstN,
    input logic            memReq,
    input logic            memAck,
    input logic            memWe,
    input logic [xlen-1:0] memAddr,
    input logic [xlen-1:0] memWdata,
    input logic            wrEn,
    input logic            halted,
    input ctrlState        state
);

    // a new request starts only once the previous ack has dropped
    reqAfterAckLow: assert property (@(posedge clk) disable iff (!arstN)
        $rose(memReq) |-> !$past(memAck))
        else $error("memReq rose while memAck was still high");

    reqPayloadStable: assert property (@(posedge clk) disable iff (!arstN)
        memReq && $past(memReq) |-> $stable(memAddr) && $stable(memWe) && $stable(memWdata))
        else $error("bus address, write enable or write data changed during a request");

    noWriteInHalt: assert property (@(posedge clk) disable iff (!arstN)
        state == stHalt |-> !wrEn)
        else $error("register write while halted");

    idleWhenHalted: assert property (@(posedge clk) disable iff (!arstN)
        halted |-> !memReq)
        else $error("memory request while halted");

    quietAfterReset: assert property (@(posedge clk)
        $rose(arstN) |-> !memReq && !halted)
        else $error("memReq or halted high in the first cycle after reset");

endmodule

bind rvCore busProtocolChk chk (
    .clk(clk), .arstN(arstN), .memReq(memReq), .memAck(memAck), .memWe(memWe),
    .memAddr(memAddr), .memWdata(memWdata), .wrEn(wrEn), .halted(halted),
    .state(uControl.state)
);

//--- sim/rvCoreGolden.hex
// header: program length, store record count; then program words from address 0x100
// store records after the program: test number, address, data
0000003A 00000010
30000F93 // addi x31, x0, 0x300
FF900093 // addi x1, x0, -7
00300113 // addi x2, x0, 3
402081B3 // sub  x3, x1, x2
003FA023 // sw   x3, 0(x31)
4020D233 // sra  x4, x1, x2
004FA223 // sw   x4, 4(x31)
001132B3 // sltu x5, x2, x1
005FA423 // sw   x5, 8(x31)
0020D333 // srl  x6, x1, x2
006FA623 // sw   x6, 12(x31)
0020C3B3 // xor  x7, x1, x2
007FA823 // sw   x7, 16(x31)
00112433 // slt  x8, x2, x1
008FAA23 // sw   x8, 20(x31)
FFFFF4B7 // lui  x9, 0xfffff
FFF48493 // addi x9, x9, -1
009FAC23 // sw   x9, 24(x31)
4010D513 // srai x10, x1, 1
00AFAE23 // sw   x10, 28(x31)
00001597 // auipc x11, 1 at 0x150
02BFA023 // sw   x11, 32(x31)
0F00F613 // andi x12, x1, 0xf0
02CFA223 // sw   x12, 36(x31)
00208463 00210463 0E0FA823 // beq not taken, beq taken, stray store at 0x3f0
00211463 00209463 0E0FA823 // bne
00114463 0020C463 0E0FA823 // blt
0020D463 00115463 0E0FA823 // bge
0020E463 00116463 0E0FA823 // bltu
00117463 0020F463 0E0FA823 // bgeu
022FA423 // sw   x2, 40(x31) marker after branches
00C006EF // jal  x13, +12 at 0x1ac
0E0FA823 // skipped
0E0FA823 // skipped
02DFA623 // sw   x13, 44(x31)
1C800713 // addi x14, x0, 0x1c8
001707E7 // jalr x15, 1(x14) at 0x1c0
0E0FA823 // skipped
02FFA823 // sw   x15, 48(x31) at 0x1c8
021FAA23 // sw   x1, 52(x31)
034FA803 // lw   x16, 52(x31)
030FAC23 // sw   x16, 56(x31)
00508013 // addi x0, x1, 5
020FAE23 // sw   x0, 60(x31)
00000073 // ecall
0E0FA823 // never fetched
00000001 00000300 FFFFFFF6 // sub
00000001 00000304 FFFFFFFF // sra
00000001 00000308 00000001 // sltu
00000001 0000030C 1FFFFFFF // srl
00000001 00000310 FFFFFFFA // xor
00000001 00000314 00000000 // slt
00000002 00000318 FFFFEFFF // lui then addi
00000002 0000031C FFFFFFFC // srai
00000002 00000320 00001150 // auipc
00000002 00000324 000000F0 // andi
00000003 00000328 00000003 // branch marker
00000004 0000032C 000001B0 // jal link
00000004 00000330 000001C4 // jalr link
00000005 00000334 FFFFFFF9 // stored word
00000005 00000338 FFFFFFF9 // loaded back
00000005 0000033C 00000000 // x0

//--- sim/rvCoreTb.sv
`timescale 1ns/1ps

module rvCoreTb;
    localparam logic [31:0] resetPc       = 32'h0000_0100;
    localparam int          memDepth      = 256;
    localparam int          goldenDepth   = 128;
    localparam int          maxAckDelay   = 3;
    localparam int          seed          = 2814;
    localparam int          cyclesPerItem = 40;  // budget per instruction or store

    logic        clk;
    logic        arstN;
    logic        memReq;
    logic        memAck;
    logic        memWe;
    logic [31:0] memAddr;
    logic [31:0] memWdata;
    logic [31:0] memRdata;
    logic        halted;

    logic [31:0] mem    [memDepth];
    logic [31:0] golden [goldenDepth];

    int progLen;
    int storeCount;
    int recBase;       // first store record in golden
    int recIdx;
    int checks;
    int errors;
    int testErrStart;
    int testStores;
    int cycles;
    int cycleLimit;

    rvCore #(.resetPc(resetPc)) dut (
        .clk(clk), .arstN(arstN), .memReq(memReq), .memAck(memAck), .memWe(memWe),
        .memAddr(memAddr), .memWdata(memWdata), .memRdata(memRdata), .halted(halted)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
    end

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            $display("Mismatch at %0d ns: %s is %08h, expected %08h",
                     $time, name, actual, expected);
            errors++;
        end
    endtask

    // compares one bus write with the next golden record
    task automatic checkStore(input logic [31:0] addr, input logic [31:0] data);
        int base;
        int testNum;
        if (recIdx >= storeCount) begin
            $display("unexpected store of %08h to %08h after all expected stores", data, addr);
            errors++;
        end else begin
            base    = recBase + 3 * recIdx;
            testNum = int'(golden[base]);
            checkValue("memAddr", addr, golden[base + 1]);
            checkValue("memWdata", data, golden[base + 2]);
            recIdx++;
            testStores++;
            if (recIdx == storeCount || golden[recBase + 3 * recIdx] != golden[base]) begin
                if (errors == testErrStart) begin
                    $display("test %0d ok, %0d stores checked", testNum, testStores);
                end else begin
                    $display("test %0d had %0d errors", testNum, errors - testErrStart);
                end
                testErrStart = errors;
                testStores   = 0;
            end
        end
    endtask

    // memory answers each request after a random delay, then waits for memReq to drop
    initial begin : memoryModel
        int ackDelay;
        void'($urandom(seed));
        forever begin
            @(posedge clk);
            #5;
            if (memReq) begin
                ackDelay = int'($urandom % (maxAckDelay + 1));
                repeat (ackDelay) begin
                    @(posedge clk);
                    #5;
                end
                if (memWe) begin
                    mem[memAddr[9:2]] = memWdata;
                    checkStore(memAddr, memWdata);
                end else begin
                    memRdata = mem[memAddr[9:2]];
                end
                memAck = 1'b1;
                while (memReq) begin
                    @(posedge clk);
                    #5;
                end
                memAck = 1'b0;
            end
        end
    end

    initial begin
        int lateEvents;
        arstN    = 1'b0;
        memAck   = 1'b0;
        memRdata = '0;
        for (int i = 0; i < memDepth; i++) begin
            mem[i] = 32'hA5A5_0000 ^ 32'(i << 2);  // byte address pattern
        end
        for (int i = 0; i < goldenDepth; i++) begin
            golden[i] = '0;
        end
        $readmemh("sim/rvCoreGolden.hex", golden);
        progLen    = int'(golden[0]);
        storeCount = int'(golden[1]);
        recBase    = 2 + progLen;
        if (progLen == 0) begin
            $display("golden file is missing or holds no program");
            errors++;
        end
        for (int i = 0; i < progLen; i++) begin
            mem[int'(resetPc[9:2]) + i] = golden[2 + i];
        end
        cycleLimit = (progLen + storeCount) * cyclesPerItem;

        repeat (2) @(posedge clk);
        #5;
        arstN = 1'b1;

        while (!halted && cycles < cycleLimit) begin
            @(posedge clk);
            #5;
        end

        if (!halted) begin
            $display("timeout: core did not halt within %0d cycles", cycleLimit);
            errors++;
        end else begin
            lateEvents = 0;
            repeat (8) begin
                @(posedge clk);
                #5;
                if (memReq || !halted) lateEvents++;
            end
            if (recIdx != storeCount) begin
                $display("core halted after %0d of %0d expected stores", recIdx, storeCount);
                errors++;
            end
            if (lateEvents == 0) begin
                $display("test 6 ok, core halted and stayed idle");
            end else begin
                $display("test 6: core left halt or requested memory after halting");
                errors++;
            end
        end

        $display("%0d checks, %0d errors, %0d of %0d stores seen",
                 checks, errors, recIdx, storeCount);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
